//--- rtl/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 32;

	// instruction field positions
	localparam int opMsb = 31;
	localparam int opLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18;
	localparam int rcLsb = 15;
	localparam int immWidth = 19; // bits 18..0, sign-extended

	typedef enum logic [4:0] {
		opAdd  = 5'b00000,
		opSub  = 5'b00001,
		opAnd  = 5'b00010,
		opOr   = 5'b00011,
		opNot  = 5'b00100,
		opMul  = 5'b00101,
		opDiv  = 5'b00110,
		opRol  = 5'b00111,
		opRor  = 5'b01000,
		opShr  = 5'b01001,
		opShra = 5'b01010,
		opShl  = 5'b01011,
		opNeg  = 5'b01100,
		opLdi  = 5'b01101,
		opHalt = 5'b11111
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluNot, aluMul, aluDiv,
		aluRol, aluRor, aluShr, aluShra, aluShl, aluNeg
	} aluOpE;

	typedef enum logic [2:0] {
		stepT0 = 3'd0,
		stepT1 = 3'd1,
		stepT2 = 3'd2,
		stepT3 = 3'd3,
		stepT4 = 3'd4,
		stepT5 = 3'd5,
		stepStopped = 3'd7
	} stepE;

	typedef enum logic [2:0] {
		busNone, busPc, busZLow, busMdr, busReg, busImm
	} busSrcE;

	function automatic aluOpE opToAlu(opcodeE op);
		case (op)
			opSub:   return aluSub;
			opAnd:   return aluAnd;
			opOr:    return aluOr;
			opNot:   return aluNot;
			opMul:   return aluMul;
			opDiv:   return aluDiv;
			opRol:   return aluRol;
			opRor:   return aluRor;
			opShr:   return aluShr;
			opShra:  return aluShra;
			opShl:   return aluShl;
			opNeg:   return aluNeg;
			default: return aluAdd; // add, and anything that is not an ALU op
		endcase
	endfunction

endpackage

//--- rtl/registerFile.sv
`timescale 1ns/100ps
module registerFile (
	input  logic                         Clock,
	input  logic                         rstN,
	input  logic [3:0]                   regIndex,
	input  logic                         regEn,
	input  logic [cpuPkg::dataWidth-1:0] bus,
	output logic [cpuPkg::dataWidth-1:0] regOut
);

	logic [cpuPkg::dataWidth-1:0] regs [16]; // R0..R15

	assign regOut = regs[regIndex]; // combinational read onto the bus mux

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (regEn) begin
			regs[regIndex] <= bus;
		end
	end

endmodule

//--- rtl/aluUnit.sv
`timescale 1ns/100ps
module aluUnit (
	input  cpuPkg::aluOpE                  aluOp,
	input  logic [cpuPkg::dataWidth-1:0]   y,
	input  logic [cpuPkg::dataWidth-1:0]   b,
	output logic [2*cpuPkg::dataWidth-1:0] result
);

	localparam int w = cpuPkg::dataWidth;

	logic [$clog2(w)-1:0] amount;
	logic [2*w-1:0]       ySx;
	logic [2*w-1:0]       bSx;
	logic [2*w-1:0]       product;
	logic [2*w-1:0]       rotL;
	logic [2*w-1:0]       rotR;
	logic [w-1:0]         quotient;
	logic [w-1:0]         remainder;

	assign amount = b[$clog2(w)-1:0]; // shifts use the low bits of Rc only

	// low half of the product of the sign-extended words is the signed product
	assign ySx = {{w{y[w-1]}}, y};
	assign bSx = {{w{b[w-1]}}, b};
	assign product = ySx * bSx;

	// rotate by shifting a doubled word
	assign rotL = {y, y} << amount;
	assign rotR = {y, y} >> amount;

	always_comb begin
		if (b == '0) begin
			quotient = '1; // divide by zero
			remainder = y;
		end else begin
			quotient = $signed(y) / $signed(b);
			remainder = $signed(y) % $signed(b);
		end
	end

	// not and neg act on Y, which holds Rb
	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd:  result = {{w{1'b0}}, y + b};
			cpuPkg::aluSub:  result = {{w{1'b0}}, y - b};
			cpuPkg::aluAnd:  result = {{w{1'b0}}, y & b};
			cpuPkg::aluOr:   result = {{w{1'b0}}, y | b};
			cpuPkg::aluNot:  result = {{w{1'b0}}, ~y};
			cpuPkg::aluNeg:  result = {{w{1'b0}}, -y};
			cpuPkg::aluShl:  result = {{w{1'b0}}, y << amount};
			cpuPkg::aluShr:  result = {{w{1'b0}}, y >> amount};
			cpuPkg::aluShra: result = {{w{1'b0}}, $signed(y) >>> amount};
			cpuPkg::aluRol:  result = {{w{1'b0}}, rotL[2*w-1:w]};
			cpuPkg::aluRor:  result = {{w{1'b0}}, rotR[w-1:0]};
			cpuPkg::aluMul:  result = product; // HI upper, LO lower
			cpuPkg::aluDiv:  result = {remainder, quotient};
			default:         result = '0;
		endcase
	end

endmodule

//--- rtl/resultUnit.sv
`timescale 1ns/100ps
module resultUnit (
	input  logic                           Clock,
	input  logic                           rstN,
	input  logic                           zEn,
	input  logic                           hiLoEn,
	input  logic                           regEn,
	input  logic [3:0]                     regIndex,
	input  logic [2*cpuPkg::dataWidth-1:0] aluResult,
	input  logic [cpuPkg::dataWidth-1:0]   bus,
	output logic [cpuPkg::dataWidth-1:0]   zLow,
	output logic                           regWrite,
	output logic [3:0]                     regIndexOut,
	output logic [cpuPkg::dataWidth-1:0]   regData,
	output logic [cpuPkg::dataWidth-1:0]   hi,
	output logic [cpuPkg::dataWidth-1:0]   lo
);

	logic [2*cpuPkg::dataWidth-1:0] z;

	assign zLow = z[cpuPkg::dataWidth-1:0];

	always_ff @(posedge Clock) begin
		if (zEn) z <= aluResult;
		regIndexOut <= regIndex; // report trails the register write by one cycle
		regData <= bus;
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			regWrite <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else begin
			regWrite <= regEn;
			if (hiLoEn) begin
				hi <= z[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];
				lo <= z[cpuPkg::dataWidth-1:0];
			end
		end
	end

	// a write-back goes either to HI/LO or to a general register
	oneWriteBack: assert property (@(posedge Clock) disable iff (!rstN)
		!(hiLoEn && regEn));

endmodule

//--- rtl/busDatapath.sv
`timescale 1ns/100ps
module busDatapath #(
	parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
	input  logic                         Clock,
	input  logic                         rstN,
	input  cpuPkg::busSrcE               busSrc,
	input  logic [3:0]                   regIndex,
	input  logic                         pcEn,
	input  logic                         marEn,
	input  logic                         mdrEn,
	input  logic                         irEn,
	input  logic                         yEn,
	input  logic                         zEn,
	input  logic                         hiLoEn,
	input  logic                         regEn,
	input  logic                         incPc,
	input  cpuPkg::aluOpE                aluOp,
	input  logic [cpuPkg::dataWidth-1:0] memData,
	output logic [cpuPkg::dataWidth-1:0] ir,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic                         regWrite,
	output logic [3:0]                   regIndexOut,
	output logic [cpuPkg::dataWidth-1:0] regData,
	output logic [cpuPkg::dataWidth-1:0] hi,
	output logic [cpuPkg::dataWidth-1:0] lo
);

	localparam int w = cpuPkg::dataWidth;

	logic [w-1:0]   bus;
	logic [w-1:0]   pc;
	logic [w-1:0]   mar;
	logic [w-1:0]   mdr;
	logic [w-1:0]   y;
	logic [w-1:0]   regOut;
	logic [w-1:0]   zLow;
	logic [w-1:0]   imm;
	logic [2*w-1:0] aluOut;
	logic [2*w-1:0] zIn;

	assign imm = {{(w - cpuPkg::immWidth){ir[cpuPkg::immWidth-1]}}, ir[cpuPkg::immWidth-1:0]};
	assign memAddr = mar;

	always_comb begin
		case (busSrc)
			cpuPkg::busPc:   bus = pc;
			cpuPkg::busZLow: bus = zLow;
			cpuPkg::busMdr:  bus = mdr;
			cpuPkg::busReg:  bus = regOut;
			cpuPkg::busImm:  bus = imm;
			default:         bus = '0; // nothing drives the bus
		endcase
	end

	// in T0 the incrementer takes the place of the ALU
	assign zIn = incPc ? {{w{1'b0}}, bus + w'(1)} : aluOut;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			ir <= '0;
		end else begin
			if (pcEn) pc <= bus;
			if (irEn) ir <= bus;
		end
	end

	always_ff @(posedge Clock) begin
		if (marEn) mar <= bus;
		if (mdrEn) mdr <= memData; // only memory feeds MDR
		if (yEn) y <= bus;
	end

	registerFile regFile (
		.Clock    (Clock),
		.rstN     (rstN),
		.regIndex (regIndex),
		.regEn    (regEn),
		.bus      (bus),
		.regOut   (regOut)
	);

	aluUnit alu (
		.aluOp  (aluOp),
		.y      (y),
		.b      (bus),
		.result (aluOut)
	);

	resultUnit result (
		.Clock       (Clock),
		.rstN        (rstN),
		.zEn         (zEn),
		.hiLoEn      (hiLoEn),
		.regEn       (regEn),
		.regIndex    (regIndex),
		.aluResult   (zIn),
		.bus         (bus),
		.zLow        (zLow),
		.regWrite    (regWrite),
		.regIndexOut (regIndexOut),
		.regData     (regData),
		.hi          (hi),
		.lo          (lo)
	);

endmodule

//--- rtl/controlSequencer.sv
`timescale 1ns/100ps
module controlSequencer (
	input  logic                         Clock,
	input  logic                         rstN,
	input  logic [cpuPkg::dataWidth-1:0] ir,
	output cpuPkg::busSrcE               busSrc,
	output logic [3:0]                   regIndex,
	output logic                         pcEn,
	output logic                         marEn,
	output logic                         mdrEn,
	output logic                         irEn,
	output logic                         yEn,
	output logic                         zEn,
	output logic                         hiLoEn,
	output logic                         regEn,
	output logic                         incPc,
	output logic                         memRead,
	output logic                         halted,
	output cpuPkg::aluOpE                aluOp
);

	cpuPkg::stepE   step;
	cpuPkg::stepE   nextStep;
	cpuPkg::opcodeE opcode;
	logic [3:0]     ra;
	logic [3:0]     rb;
	logic [3:0]     rc;
	logic           running; // low for the first cycle out of reset
	logic           isHiLo;

	assign opcode = cpuPkg::opcodeE'(ir[cpuPkg::opMsb:cpuPkg::opLsb]);
	assign ra = ir[cpuPkg::raMsb:cpuPkg::raLsb];
	assign rb = ir[cpuPkg::rbMsb:cpuPkg::rbLsb];
	assign rc = ir[cpuPkg::rcMsb:cpuPkg::rcLsb];
	assign isHiLo = (opcode == cpuPkg::opMul) || (opcode == cpuPkg::opDiv);

	assign aluOp = cpuPkg::opToAlu(opcode); // valid in every step
	assign halted = (step == cpuPkg::stepStopped);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			step <= cpuPkg::stepT0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (running) begin
				step <= nextStep;
			end
		end
	end

	always_comb begin
		busSrc = cpuPkg::busNone;
		regIndex = ra; // write-back target unless a step reads rb or rc
		pcEn = 1'b0;
		marEn = 1'b0;
		mdrEn = 1'b0;
		irEn = 1'b0;
		yEn = 1'b0;
		zEn = 1'b0;
		hiLoEn = 1'b0;
		regEn = 1'b0;
		incPc = 1'b0;
		memRead = 1'b0;
		nextStep = step;
		if (running) begin
			case (step)
				cpuPkg::stepT0: begin // MAR <- PC, Z <- PC + 1
					busSrc = cpuPkg::busPc;
					marEn = 1'b1;
					incPc = 1'b1;
					zEn = 1'b1;
					nextStep = cpuPkg::stepT1;
				end
				cpuPkg::stepT1: begin // PC <- Z low, MDR <- memory
					busSrc = cpuPkg::busZLow;
					pcEn = 1'b1;
					memRead = 1'b1;
					mdrEn = 1'b1;
					nextStep = cpuPkg::stepT2;
				end
				cpuPkg::stepT2: begin
					busSrc = cpuPkg::busMdr;
					irEn = 1'b1;
					nextStep = cpuPkg::stepT3;
				end
				cpuPkg::stepT3: begin
					if (opcode == cpuPkg::opHalt) begin
						nextStep = cpuPkg::stepStopped;
					end else if (opcode == cpuPkg::opLdi) begin
						busSrc = cpuPkg::busImm; // Ra <- immediate, done in 4 steps
						regEn = 1'b1;
						nextStep = cpuPkg::stepT0;
					end else begin
						busSrc = cpuPkg::busReg;
						regIndex = rb;
						yEn = 1'b1;
						nextStep = cpuPkg::stepT4;
					end
				end
				cpuPkg::stepT4: begin // Z <- Y op Rc
					busSrc = cpuPkg::busReg;
					regIndex = rc;
					zEn = 1'b1;
					nextStep = cpuPkg::stepT5;
				end
				cpuPkg::stepT5: begin
					if (isHiLo) begin
						hiLoEn = 1'b1;
					end else begin
						busSrc = cpuPkg::busZLow;
						regEn = 1'b1;
					end
					nextStep = cpuPkg::stepT0;
				end
				default: nextStep = cpuPkg::stepStopped; // stays here until reset
			endcase
		end
	end

	// every enable that loads from the bus needs a driver on it
	busDriven: assert property (@(posedge Clock) disable iff (!rstN)
		(pcEn || marEn || irEn || yEn || zEn || regEn) |-> busSrc != cpuPkg::busNone);

	readOnlyInT1: assert property (@(posedge Clock) disable iff (!rstN)
		memRead |-> step == cpuPkg::stepT1);

	// only a known ALU opcode may reach the execute step
	aluOpcodeInT4: assert property (@(posedge Clock) disable iff (!rstN)
		(step == cpuPkg::stepT4) |->
			!$isunknown(opcode) && (opcode inside {[cpuPkg::opAdd:cpuPkg::opNeg]}));

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/100ps
module cpuTop #(
	parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
	input  logic                         Clock,
	input  logic                         rstN,
	input  logic [cpuPkg::dataWidth-1:0] memData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic                         memRead,
	output logic                         regWrite,
	output logic [3:0]                   regIndex,
	output logic [cpuPkg::dataWidth-1:0] regData,
	output logic [cpuPkg::dataWidth-1:0] hi,
	output logic [cpuPkg::dataWidth-1:0] lo,
	output logic                         halted
);

	cpuPkg::busSrcE               busSrc;
	cpuPkg::aluOpE                aluOp;
	logic [3:0]                   selIndex; // register picked by the sequencer
	logic [cpuPkg::dataWidth-1:0] ir;
	logic                         pcEn;
	logic                         marEn;
	logic                         mdrEn;
	logic                         irEn;
	logic                         yEn;
	logic                         zEn;
	logic                         hiLoEn;
	logic                         regEn;
	logic                         incPc;

	controlSequencer sequencer (
		.Clock    (Clock),
		.rstN     (rstN),
		.ir       (ir),
		.busSrc   (busSrc),
		.regIndex (selIndex),
		.pcEn     (pcEn),
		.marEn    (marEn),
		.mdrEn    (mdrEn),
		.irEn     (irEn),
		.yEn      (yEn),
		.zEn      (zEn),
		.hiLoEn   (hiLoEn),
		.regEn    (regEn),
		.incPc    (incPc),
		.memRead  (memRead),
		.halted   (halted),
		.aluOp    (aluOp)
	);

	busDatapath #(
		.resetPc (resetPc)
	) datapath (
		.Clock       (Clock),
		.rstN        (rstN),
		.busSrc      (busSrc),
		.regIndex    (selIndex),
		.pcEn        (pcEn),
		.marEn       (marEn),
		.mdrEn       (mdrEn),
		.irEn        (irEn),
		.yEn         (yEn),
		.zEn         (zEn),
		.hiLoEn      (hiLoEn),
		.regEn       (regEn),
		.incPc       (incPc),
		.aluOp       (aluOp),
		.memData     (memData),
		.ir          (ir),
		.memAddr     (memAddr),
		.regWrite    (regWrite),
		.regIndexOut (regIndex),
		.regData     (regData),
		.hi          (hi),
		.lo          (lo)
	);

endmodule

//--- test/cpuTb.sv
`timescale 1ns/100ps
module cpuTb;

	localparam logic [31:0] resetPc = 32'h0000_0040;
	localparam int progLen = 57; // 16 ldi, 40 ALU, halt
	localparam int cycleLimit = 6 * progLen + 50;

	logic        Clock;
	logic        rstN;
	logic [31:0] memData;
	logic [31:0] memAddr;
	logic        memRead;
	logic        regWrite;
	logic [3:0]  regIndex;
	logic [31:0] regData;
	logic [31:0] hi;
	logic [31:0] lo;
	logic        halted;

	logic [31:0] progMem [64];
	logic [3:0]  expIndex [64]; // expected register writes in order
	logic [31:0] expData [64];
	logic [31:0] expHi [progLen + 1]; // HI/LO seen at each fetch, last entry after halt
	logic [31:0] expLo [progLen + 1];
	int          expWrites;
	int          writeCount;
	int          fetchCount;
	int          cycleCount;
	int unsigned seed;

	cpuTop #(
		.resetPc (resetPc)
	) dut (
		.Clock    (Clock),
		.rstN     (rstN),
		.memData  (memData),
		.memAddr  (memAddr),
		.memRead  (memRead),
		.regWrite (regWrite),
		.regIndex (regIndex),
		.regData  (regData),
		.hi       (hi),
		.lo       (lo),
		.halted   (halted)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	function automatic logic [31:0] aluWord(cpuPkg::opcodeE op, int ra, int rb, int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'h0};
	endfunction

	function automatic logic [31:0] ldiWord(int ra, logic [18:0] imm);
		return {cpuPkg::opLdi, 4'(ra), 4'h0, imm};
	endfunction

	// {HI, LO} of one ALU instruction with operands Rb and Rc
	function automatic logic [63:0] expectedAlu(cpuPkg::opcodeE op, logic [31:0] b,
			logic [31:0] c);
		logic [4:0] n;
		longint     sb;
		longint     sc;
		n = c[4:0]; // shift amount from the low five bits only
		sb = longint'($signed(b));
		sc = longint'($signed(c));
		case (op)
			cpuPkg::opAdd:  return {32'h0, b + c};
			cpuPkg::opSub:  return {32'h0, b - c};
			cpuPkg::opAnd:  return {32'h0, b & c};
			cpuPkg::opOr:   return {32'h0, b | c};
			cpuPkg::opNot:  return {32'h0, ~b};
			cpuPkg::opNeg:  return {32'h0, 32'h0 - b};
			cpuPkg::opShl:  return {32'h0, b << n};
			cpuPkg::opShr:  return {32'h0, b >> n};
			cpuPkg::opShra: return {32'h0, 32'(sb >>> n)};
			cpuPkg::opRol:  return {32'h0, (b << n) | (b >> (32 - int'(n)))};
			cpuPkg::opRor:  return {32'h0, (b >> n) | (b << (32 - int'(n)))};
			cpuPkg::opMul:  return 64'(sb * sc);
			cpuPkg::opDiv: begin
				if (c == 32'h0) begin
					return {b, 32'hFFFF_FFFF}; // divide by zero
				end
				return {32'(sb % sc), 32'(sb / sc)};
			end
			default: return 64'h0;
		endcase
	endfunction

	task automatic buildProgram();
		logic [18:0] imm;
		for (int a = 0; a < 64; a++) begin
			progMem[a] = {cpuPkg::opHalt, 27'(a)}; // unused words are halts tagged by address
		end
		for (int r = 0; r < 16; r++) begin
			imm = 19'($urandom);
			if (r == 15) begin
				imm[18] = 1'b1; // R15 negative for the shra case
			end
			progMem[r] = ldiWord(r, imm);
		end
		progMem[16] = aluWord(cpuPkg::opSub, 1, 2, 2); // R1 becomes zero
		progMem[17] = aluWord(cpuPkg::opDiv, 3, 4, 1);
		progMem[18] = aluWord(cpuPkg::opNeg, 5, 6, 0);
		progMem[19] = aluWord(cpuPkg::opShra, 8, 15, 9);
		for (int i = 20; i < progLen - 1; i++) begin
			progMem[i] = aluWord(cpuPkg::opcodeE'(5'($urandom_range(12, 0))),
				$urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0));
		end
		progMem[progLen - 1] = {cpuPkg::opHalt, 27'h0};
	endtask

	// walks the program in order and records every expected write
	task automatic runModel();
		logic [31:0]    regs [16];
		logic [31:0]    hiM;
		logic [31:0]    loM;
		logic [63:0]    r;
		logic [3:0]     ra;
		cpuPkg::opcodeE op;
		for (int i = 0; i < 16; i++) begin
			regs[i] = 32'h0;
		end
		hiM = 32'h0;
		loM = 32'h0;
		expWrites = 0;
		for (int k = 0; k < progLen; k++) begin
			expHi[k] = hiM;
			expLo[k] = loM;
			op = cpuPkg::opcodeE'(progMem[k][31:27]);
			ra = progMem[k][26:23];
			if (op == cpuPkg::opLdi) begin
				regs[ra] = {{13{progMem[k][18]}}, progMem[k][18:0]};
				expIndex[expWrites] = ra;
				expData[expWrites] = regs[ra];
				expWrites++;
			end else if (op != cpuPkg::opHalt) begin
				r = expectedAlu(op, regs[progMem[k][22:19]], regs[progMem[k][18:15]]);
				if (op == cpuPkg::opMul || op == cpuPkg::opDiv) begin
					hiM = r[63:32];
					loM = r[31:0];
				end else begin
					regs[ra] = r[31:0];
					expIndex[expWrites] = ra;
					expData[expWrites] = r[31:0];
					expWrites++;
				end
			end
		end
		expHi[progLen] = hiM;
		expLo[progLen] = loM;
	endtask

	function automatic logic [31:0] fetchWord(logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - resetPc;
		if (offset < 64) begin
			return progMem[offset[5:0]];
		end
		return {cpuPkg::opHalt, addr[26:0]};
	endfunction

	task automatic reportValue(string name, logic [31:0] expected, logic [31:0] actual);
		$display("test failed");
		$display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
		$fatal(1);
	endtask

	task automatic reportEvent(string what);
		$display("test failed");
		$display("Error at %0t: %s", $time, what);
		$fatal(1);
	endtask

	always @(negedge Clock) begin
		if (memRead) begin
			memData <= fetchWord(memAddr); // memory answers within T1
		end
	end

	always @(posedge Clock) begin
		if (!rstN) begin
			fetchCount <= 0;
			writeCount <= 0;
		end else begin
			if (memRead) fetchCount <= fetchCount + 1;
			if (regWrite) writeCount <= writeCount + 1;
		end
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("test failed");
			$display("Timeout: halt not reached after %0d cycles", cycleLimit);
			$fatal(1);
		end
	end

	resetQuiet: assert property (@(posedge Clock) $rose(rstN) |-> !memRead && !regWrite && !halted)
		else reportEvent("memRead, regWrite or halted high right after reset");

	fetchOrder: assert property (@(posedge Clock) disable iff (!rstN)
		memRead |-> memAddr == resetPc + fetchCount)
		else reportValue("memAddr", resetPc + $sampled(fetchCount), $sampled(memAddr));

	hiAtFetch: assert property (@(posedge Clock) disable iff (!rstN)
		memRead |-> hi == expHi[fetchCount])
		else reportValue("hi", expHi[$sampled(fetchCount)], $sampled(hi));

	loAtFetch: assert property (@(posedge Clock) disable iff (!rstN)
		memRead |-> lo == expLo[fetchCount])
		else reportValue("lo", expLo[$sampled(fetchCount)], $sampled(lo));

	writeExpected: assert property (@(posedge Clock) disable iff (!rstN)
		regWrite |-> writeCount < expWrites)
		else reportEvent("register write after the last expected one");

	writeIndex: assert property (@(posedge Clock) disable iff (!rstN)
		regWrite |-> regIndex == expIndex[writeCount])
		else reportValue("regIndex", expIndex[$sampled(writeCount)], $sampled(regIndex));

	writeData: assert property (@(posedge Clock) disable iff (!rstN)
		regWrite |-> regData == expData[writeCount])
		else reportValue("regData", expData[$sampled(writeCount)], $sampled(regData));

	haltedStays: assert property (@(posedge Clock) disable iff (!rstN) halted |=> halted)
		else reportEvent("halted dropped before reset");

	noFetchHalted: assert property (@(posedge Clock) disable iff (!rstN) halted |-> !memRead)
		else reportEvent("memRead while halted");

	haltWrites: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(halted) |-> writeCount == expWrites)
		else reportValue("regWrite count", expWrites, $sampled(writeCount));

	haltFetches: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(halted) |-> fetchCount == progLen)
		else reportValue("fetch count", progLen, $sampled(fetchCount));

	haltHi: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(halted) |-> hi == expHi[progLen])
		else reportValue("hi", expHi[progLen], $sampled(hi));

	haltLo: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(halted) |-> lo == expLo[progLen])
		else reportValue("lo", expLo[progLen], $sampled(lo));

	initial begin
		seed = $urandom(84);
		rstN = 1'b0;
		memData = 32'h0;
		cycleCount = 0;
		fetchCount = 0;
		writeCount = 0;
		buildProgram();
		runModel();
		repeat (10) @(negedge Clock);
		rstN = 1'b1;
		wait (halted);
		repeat (4) @(negedge Clock); // let halted hold for a few cycles
		$display("test passed");
		$finish;
	end

endmodule

//--- sim.f
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/resultUnit.sv
rtl/busDatapath.sv
rtl/controlSequencer.sv
rtl/cpuTop.sv
test/cpuTb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - rtl/cpuPkg.sv
  - rtl/registerFile.sv
  - rtl/aluUnit.sv
  - rtl/resultUnit.sv
  - rtl/busDatapath.sv
  - rtl/controlSequencer.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - test/cpuTb.sv
